/* bpf_exec_top.f */
source/bpf_isa_pkg.sv
source/bpf_exec_pkg.sv
source/bpf_decoder.sv
source/bpf_reg_file.sv
source/bpf_alu.sv
source/bpf_branch_unit.sv
source/bpf_exec_top.sv
verification/bpf_exec_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the BPF execution stage testbench with Verilator and runs it
# The exit status is the simulator's, so a $fatal in the testbench fails the script

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module bpf_exec_tb -f bpf_exec_top.f -o bpf_exec_sim \
    && ./obj_dir/bpf_exec_sim \
    || { echo "Simulation did not pass" >&2; exit 1; }

/* verification/bpf_exec_tb.sv */
module bpf_exec_tb;
    import bpf_isa_pkg::*;
    import bpf_exec_pkg::*;

    localparam int DRIVE_DELAY    = 10;  // Inputs change this long after the rising edge
    localparam int RESET_CYCLES   = 10;
    localparam int HOLD_CYCLES    = 3;   // Cycles a result waits for its ack
    localparam int WAIT_LIMIT     = 8;   // Longest wait for valid or illegal after issue
    localparam int CYCLES_PER_ROW = 20;

    // One line of the stimulus table
    typedef struct packed {
        bpf_word_t  a;       // Preload for the accumulator
        bpf_word_t  x;       // Preload for the index register
        bpf_instr_t instr;
        logic       rand_k;  // Replace K with a random word at issue time
    } row_t;

    logic         clk;
    logic         rst_n_i;
    logic         reg_wr_i;
    bpf_reg_sel_t reg_wr_sel_i;
    bpf_word_t    reg_wr_data_i;
    logic         instr_valid_i;
    bpf_instr_t   instr_i;
    logic         ack_i;
    bpf_word_t    result_o;
    bpf_flags_t   flags_o;
    logic         result_valid_o;
    logic         jump_taken_o;
    bpf_offset_t  pc_offset_o;
    logic         illegal_o;
    bpf_word_t    a_o;
    bpf_word_t    x_o;
    row_t         rows[$];
    integer       seed = 32'he2ae57d7;
    logic         table_ready = 1'b0;  // Lets the watchdog size itself from the table

    bpf_exec_top bpf_exec_top_inst (
        .clk(clk), .rst_n_i(rst_n_i), .reg_wr_i(reg_wr_i), .reg_wr_sel_i(reg_wr_sel_i),
        .reg_wr_data_i(reg_wr_data_i), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
        .ack_i(ack_i), .result_o(result_o), .flags_o(flags_o),
        .result_valid_o(result_valid_o), .jump_taken_o(jump_taken_o),
        .pc_offset_o(pc_offset_o), .illegal_o(illegal_o), .a_o(a_o), .x_o(x_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // Period of 100
    end

    initial begin
        wait (table_ready);
        repeat (RESET_CYCLES + rows.size() * CYCLES_PER_ROW) @(posedge clk);
        $display("Test failed");
        $fatal(1, "Watchdog expired before the stimulus table was finished");
    end

    // Opcode layout is op in bits 7:4, source in bit 3 and class in bits 2:0
    function automatic bpf_opcode_t make_opcode(input logic [3:0] op, input logic src,
                                                input bpf_class_t cls);
        return {8'h00, op, src, cls};
    endfunction

    function automatic bpf_word_t model_result(input logic [3:0] op, input bpf_word_t a,
                                               input bpf_word_t b);
        case (op)
            4'h0: return a + b;
            4'h1: return a - b;
            4'h2: return MUL_MARKER;
            4'h3: return DIV_MARKER;
            4'h4: return a | b;
            4'h5: return a & b;
            4'h6: return (b >= 32) ? 32'd0 : (a << b[4:0]);  // Long shifts empty the word
            4'h7: return (b >= 32) ? 32'd0 : (a >> b[4:0]);
            4'h8: return ~a;
            4'h9: return MOD_MARKER;
            4'ha: return a ^ b;
            default: return 32'd0;
        endcase
    endfunction

    function automatic bpf_flags_t model_flags(input bpf_word_t a, input bpf_word_t b);
        bpf_flags_t f;
        f.eq  = (a == b);
        f.gt  = (a > b);
        f.ge  = !(a < b);
        f.set = |(a & b);
        return f;
    endfunction

    function automatic logic model_illegal(input bpf_opcode_t opcode);
        if (opcode[2:0] == CLASS_ALU) begin
            return opcode[7:4] > 4'ha;
        end else if (opcode[2:0] == CLASS_JMP) begin
            return opcode[7:4] > 4'h4;
        end
        return 1'b1;  // Loads, stores, ret and misc
    endfunction

    task automatic model_branch(input bpf_instr_t instr, input bpf_flags_t f,
                                output logic taken, output bpf_offset_t offset);
        logic pred;
        case (instr.opcode[7:4])
            4'h1: pred = f.eq;
            4'h2: pred = f.gt;
            4'h3: pred = f.ge;
            4'h4: pred = f.set;
            default: pred = 1'b0;
        endcase
        taken  = 1'b0;
        offset = 8'd0;
        if (instr.opcode[2:0] == CLASS_JMP && instr.opcode[7:4] == 4'h0) begin
            taken  = 1'b1;
            offset = instr.k[7:0];  // Ja moves by the low byte of K
        end else if (instr.opcode[2:0] == CLASS_JMP) begin
            taken  = pred;
            offset = pred ? instr.jt : instr.jf;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic write_reg(input bpf_reg_sel_t sel, input bpf_word_t data);
        reg_wr_i      = 1'b1;
        reg_wr_sel_i  = sel;
        reg_wr_data_i = data;
        next_cycle();
        reg_wr_i      = 1'b0;
    endtask

    task automatic wait_for_response();
        int waited;
        waited = 0;
        while (!result_valid_o && !illegal_o) begin
            if (waited == WAIT_LIMIT) begin
                $display("Test failed");
                $fatal(1, "Neither result_valid_o nor illegal_o rose after the issue");
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    task automatic add_row(input bpf_word_t a, input bpf_word_t x, input bpf_opcode_t opcode,
                           input bpf_offset_t jt, input bpf_offset_t jf, input bpf_word_t k,
                           input logic rand_k);
        row_t r;
        r.a      = a;
        r.x      = x;
        r.instr  = '{opcode: opcode, jt: jt, jf: jf, k: k};
        r.rand_k = rand_k;
        rows.push_back(r);
    endtask

    task automatic build_table();
        for (int op = 0; op <= 10; op++) begin  // Every ALU operation from K and from X
            add_row(32'h1234_5678 + op, 32'h5, make_opcode(op[3:0], SRC_K, CLASS_ALU),
                    8'd0, 8'd0, 32'h3, 1'b0);
            add_row(32'h8000_00f1, 32'h0f0f_0f0f >> op, make_opcode(op[3:0], SRC_X, CLASS_ALU),
                    8'd0, 8'd0, 32'hffff_ffff, 1'b0);
        end
        add_row(32'hffff_ffff, 32'd0, make_opcode(ALU_LSH, SRC_K, CLASS_ALU), 0, 0, 32'd32, 0);
        add_row(32'hffff_ffff, 32'd0, make_opcode(ALU_RSH, SRC_K, CLASS_ALU), 0, 0, 32'd31, 0);
        add_row(32'hffff_ffff, 32'd40, make_opcode(ALU_LSH, SRC_X, CLASS_ALU), 0, 0, 32'd1, 0);
        add_row(32'h7fff_0000, 32'h8000_0001, make_opcode(ALU_RSH, SRC_X, CLASS_ALU), 0, 0, 0, 0);
        // Jumps with the predicate both ways, jt and jf kept apart to tell them from each other
        add_row(32'd9, 32'd0, make_opcode(JMP_JA, SRC_K, CLASS_JMP), 8'd3, 8'd4, 32'h117, 0);
        add_row(32'd5, 32'd0, make_opcode(JMP_JEQ, SRC_K, CLASS_JMP), 8'd2, 8'd9, 32'd5, 0);
        add_row(32'd5, 32'd0, make_opcode(JMP_JEQ, SRC_K, CLASS_JMP), 8'd2, 8'd9, 32'd6, 0);
        add_row(32'd7, 32'd7, make_opcode(JMP_JEQ, SRC_X, CLASS_JMP), 8'd11, 8'd12, 32'd0, 0);
        add_row(32'd10, 32'd0, make_opcode(JMP_JGT, SRC_K, CLASS_JMP), 8'd5, 8'd6, 32'd9, 0);
        add_row(32'd9, 32'd9, make_opcode(JMP_JGT, SRC_X, CLASS_JMP), 8'd5, 8'd6, 32'd0, 0);
        add_row(32'd4, 32'd0, make_opcode(JMP_JGE, SRC_K, CLASS_JMP), 8'd13, 8'd14, 32'd4, 0);
        add_row(32'd1, 32'd2, make_opcode(JMP_JGE, SRC_X, CLASS_JMP), 8'd13, 8'd14, 32'd0, 0);
        add_row(32'h10, 32'd0, make_opcode(JMP_JSET, SRC_K, CLASS_JMP), 8'd7, 8'd8, 32'h30, 0);
        add_row(32'h0f, 32'hf0, make_opcode(JMP_JSET, SRC_X, CLASS_JMP), 8'd7, 8'd8, 32'd0, 0);
        for (int i = 0; i < 8; i++) begin  // Random operands for the comparison flags
            add_row($random(seed), $random(seed), make_opcode(4'(i % 4 + 1), SRC_K, CLASS_JMP),
                    8'(i + 1), 8'(i + 20), 32'd0, 1'b1);
        end
        add_row($random(seed), 32'd0, make_opcode(ALU_ADD, SRC_K, CLASS_ALU), 0, 0, 0, 1'b1);
        add_row($random(seed), 32'd0, make_opcode(ALU_XOR, SRC_K, CLASS_ALU), 0, 0, 0, 1'b1);
        // Classes and op values the stage rejects
        add_row(32'haa, 32'hbb, 16'h0020, 8'd1, 8'd2, 32'd7, 1'b0);  // Load word absolute
        add_row(32'hcc, 32'hdd, 16'h0006, 8'd1, 8'd2, 32'd7, 1'b0);  // Return K
        add_row(32'h11, 32'h22, 16'h0007, 8'd1, 8'd2, 32'd7, 1'b0);  // Misc tax
        add_row(32'h33, 32'h44, make_opcode(4'hb, SRC_K, CLASS_ALU), 0, 0, 32'd1, 0);
        add_row(32'h55, 32'h66, make_opcode(4'h5, SRC_X, CLASS_JMP), 0, 0, 32'd1, 0);
    endtask

    initial begin
        row_t        row;
        bpf_instr_t  instr;
        bpf_word_t   b;
        bpf_word_t   exp_result;
        bpf_word_t   exp_a;
        bpf_flags_t  exp_flags;
        logic        exp_taken;
        bpf_offset_t exp_offset;
        logic        exp_illegal;
        logic        is_alu;

        rst_n_i       = 1'b0;
        reg_wr_i      = 1'b0;
        reg_wr_sel_i  = REG_SEL_A;
        reg_wr_data_i = '0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        ack_i         = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;

        check_value("result_valid_o", 32'd0, {31'd0, result_valid_o});  // Idle out of reset
        check_value("illegal_o", 32'd0, {31'd0, illegal_o});
        check_value("jump_taken_o", 32'd0, {31'd0, jump_taken_o});
        check_value("pc_offset_o", 32'd0, {24'd0, pc_offset_o});
        check_value("result_o", 32'd0, result_o);
        check_value("a_o", 32'd0, a_o);
        check_value("x_o", 32'd0, x_o);

        foreach (rows[i]) begin
            row   = rows[i];
            instr = row.instr;
            if (row.rand_k) begin
                instr.k = $random(seed);
            end
            write_reg(REG_SEL_A, row.a);
            write_reg(REG_SEL_X, row.x);
            instr_i       = instr;
            instr_valid_i = 1'b1;
            next_cycle();
            instr_valid_i = 1'b0;
            wait_for_response();

            b           = instr.opcode[3] ? row.x : instr.k;  // Source bit picks X or K
            exp_illegal = model_illegal(instr.opcode);
            is_alu      = (instr.opcode[2:0] == CLASS_ALU);
            exp_result  = model_result(instr.opcode[7:4], row.a, b);
            exp_flags   = model_flags(row.a, b);
            model_branch(instr, exp_flags, exp_taken, exp_offset);
            exp_a       = (is_alu && !exp_illegal) ? exp_result : row.a;

            for (int hold = 0; hold < HOLD_CYCLES; hold++) begin  // Nothing moves before the ack
                check_value("illegal_o", {31'd0, exp_illegal}, {31'd0, illegal_o});
                check_value("result_valid_o", {31'd0, !exp_illegal}, {31'd0, result_valid_o});
                if (!exp_illegal) begin
                    check_value("flags_o", {28'd0, exp_flags}, {28'd0, flags_o});
                    check_value("jump_taken_o", {31'd0, exp_taken}, {31'd0, jump_taken_o});
                    check_value("pc_offset_o", {24'd0, exp_offset}, {24'd0, pc_offset_o});
                end
                if (is_alu && !exp_illegal) begin
                    check_value("result_o", exp_result, result_o);
                end
                next_cycle();
            end
            ack_i = 1'b1;
            next_cycle();
            ack_i = 1'b0;
            check_value("result_valid_o", 32'd0, {31'd0, result_valid_o});
            check_value("illegal_o", 32'd0, {31'd0, illegal_o});
            next_cycle();
            check_value("a_o", exp_a, a_o);  // Writeback for ALU work, untouched otherwise
            check_value("x_o", row.x, x_o);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* source/bpf_exec_top.sv */
module bpf_exec_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        reg_wr_i,
    input  bpf_exec_pkg::bpf_reg_sel_t  reg_wr_sel_i,
    input  bpf_exec_pkg::bpf_word_t     reg_wr_data_i,
    input  logic                        instr_valid_i,
    input  bpf_exec_pkg::bpf_instr_t    instr_i,
    input  logic                        ack_i,
    output bpf_exec_pkg::bpf_word_t     result_o,
    output bpf_exec_pkg::bpf_flags_t    flags_o,
    output logic                        result_valid_o,
    output logic                        jump_taken_o,
    output bpf_exec_pkg::bpf_offset_t   pc_offset_o,
    output logic                        illegal_o,
    output bpf_exec_pkg::bpf_word_t     a_o,
    output bpf_exec_pkg::bpf_word_t     x_o
);
    import bpf_exec_pkg::*;

    bpf_decoded_t decoded;
    bpf_word_t    op_a;
    bpf_word_t    op_b;
    bpf_word_t    alu_result;
    bpf_flags_t   alu_flags;
    logic         issue_ok;     // Issue of something this stage can execute
    logic         illegal_q;

    assign issue_ok = instr_valid_i && !decoded.illegal;

    // Sticky report of a rejected instruction, cleared by the same ack as the result
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            illegal_q <= 1'b0;
        end else if (instr_valid_i && decoded.illegal) begin
            illegal_q <= 1'b1;
        end else if (ack_i) begin
            illegal_q <= 1'b0;
        end
    end

    bpf_decoder bpf_decoder_inst (
        .instr_i   (instr_i),
        .decoded_o (decoded)
    );

    bpf_reg_file bpf_reg_file_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .reg_wr_i      (reg_wr_i),
        .reg_wr_sel_i  (reg_wr_sel_i),
        .reg_wr_data_i (reg_wr_data_i),
        .issue_i       (instr_valid_i),  // Checks the illegal flag on its own
        .decoded_i     (decoded),
        .k_i           (instr_i.k),
        .alu_result_i  (alu_result),
        .op_a_o        (op_a),
        .op_b_o        (op_b),
        .a_o           (a_o),
        .x_o           (x_o)
    );

    bpf_alu bpf_alu_inst (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .alu_op_i (decoded.alu_op),
        .en_i     (issue_ok),
        .ack_i    (ack_i),
        .result_o (alu_result),
        .flags_o  (alu_flags),
        .valid_o  (result_valid_o)
    );

    bpf_branch_unit bpf_branch_unit_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .issue_i      (issue_ok),
        .decoded_i    (decoded),
        .jt_i         (instr_i.jt),
        .jf_i         (instr_i.jf),
        .k_i          (instr_i.k),
        .flags_i      (alu_flags),
        .jump_taken_o (jump_taken_o),
        .pc_offset_o  (pc_offset_o)
    );

    assign result_o  = alu_result;
    assign flags_o   = alu_flags;
    assign illegal_o = illegal_q;

endmodule

/* source/bpf_branch_unit.sv */
module bpf_branch_unit (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        issue_i,     // Already gated with not illegal
    input  bpf_exec_pkg::bpf_decoded_t  decoded_i,
    input  bpf_exec_pkg::bpf_offset_t   jt_i,
    input  bpf_exec_pkg::bpf_offset_t   jf_i,
    input  bpf_exec_pkg::bpf_word_t     k_i,
    input  bpf_exec_pkg::bpf_flags_t    flags_i,     // Registered ALU flags
    output logic                        jump_taken_o,
    output bpf_exec_pkg::bpf_offset_t   pc_offset_o
);
    import bpf_isa_pkg::*;
    import bpf_exec_pkg::*;

    logic          is_jmp_q;
    bpf_jmp_cond_t cond_q;
    bpf_offset_t   jt_q;
    bpf_offset_t   jf_q;
    bpf_offset_t   k_q;       // Low byte of K, the ja distance
    logic          pred;

    // Captured at the same edge as the ALU flags, so both line up with valid
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            is_jmp_q <= 1'b0;
            cond_q   <= JMP_JA;
            jt_q     <= '0;
            jf_q     <= '0;
            k_q      <= '0;
        end else if (issue_i) begin
            is_jmp_q <= decoded_i.is_jmp;
            cond_q   <= decoded_i.jmp_cond;
            jt_q     <= jt_i;
            jf_q     <= jf_i;
            k_q      <= k_i[7:0];
        end
    end

    always_comb begin
        case (cond_q)
            JMP_JEQ:  pred = flags_i.eq;
            JMP_JGT:  pred = flags_i.gt;
            JMP_JGE:  pred = flags_i.ge;
            JMP_JSET: pred = flags_i.set;
            default:  pred = 1'b0;  // Ja does not look at the flags
        endcase
    end

    always_comb begin
        jump_taken_o = 1'b0;
        pc_offset_o  = '0;     // Non-jumps report no movement
        if (is_jmp_q) begin
            if (cond_q == JMP_JA) begin
                jump_taken_o = 1'b1;
                pc_offset_o  = k_q;
            end else begin
                jump_taken_o = pred;
                pc_offset_o  = pred ? jt_q : jf_q;  // Fall-through distance is jf
            end
        end
    end

endmodule

/* source/bpf_alu.sv */
module bpf_alu (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  bpf_exec_pkg::bpf_word_t    op_a_i,
    input  bpf_exec_pkg::bpf_word_t    op_b_i,
    input  bpf_isa_pkg::bpf_alu_op_t   alu_op_i,
    input  logic                       en_i,      // Load the output register
    input  logic                       ack_i,     // Host has consumed the result
    output bpf_exec_pkg::bpf_word_t    result_o,
    output bpf_exec_pkg::bpf_flags_t   flags_o,
    output logic                       valid_o
);
    import bpf_isa_pkg::*;
    import bpf_exec_pkg::*;

    bpf_word_t  result_d;
    bpf_flags_t flags_d;
    bpf_word_t  result_q;
    bpf_flags_t flags_q;
    logic       valid_q;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: result_d = op_a_i + op_b_i;
            ALU_SUB: result_d = op_a_i - op_b_i;
            ALU_MUL: result_d = MUL_MARKER;        // No multiplier in this stage
            ALU_DIV: result_d = DIV_MARKER;        // No divider either
            ALU_OR:  result_d = op_a_i | op_b_i;
            ALU_AND: result_d = op_a_i & op_b_i;
            // The shift count is the whole 32-bit operand, so 32 and up clears the word
            ALU_LSH: result_d = op_a_i << op_b_i;
            ALU_RSH: result_d = op_a_i >> op_b_i;
            ALU_NEG: result_d = ~op_a_i;           // Bitwise inverse, operand B unused
            ALU_MOD: result_d = MOD_MARKER;
            ALU_XOR: result_d = op_a_i ^ op_b_i;
            default: result_d = '0;                // The decoder flags these as illegal
        endcase
    end

    // Jump predicates, all unsigned as classic BPF compares
    always_comb begin
        flags_d.eq  = (op_a_i == op_b_i);
        flags_d.gt  = (op_a_i > op_b_i);
        flags_d.ge  = (op_a_i >= op_b_i);
        flags_d.set = ((op_a_i & op_b_i) != '0);
    end

    // Output register with the valid pulse rule
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            result_q <= '0;
            flags_q  <= '0;
            valid_q  <= 1'b0;
        end else if (en_i) begin
            result_q <= result_d;  // A new issue overwrites even an unacknowledged result
            flags_q  <= flags_d;
            valid_q  <= 1'b1;
        end else if (ack_i) begin
            valid_q <= 1'b0;       // Data stays put, only valid drops
        end
    end

    assign result_o = result_q;
    assign flags_o  = flags_q;
    assign valid_o  = valid_q;

endmodule

/* source/bpf_reg_file.sv */
module bpf_reg_file (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        reg_wr_i,       // Host write strobe
    input  bpf_exec_pkg::bpf_reg_sel_t  reg_wr_sel_i,
    input  bpf_exec_pkg::bpf_word_t     reg_wr_data_i,
    input  logic                        issue_i,        // Raw issue strobe, not yet gated
    input  bpf_exec_pkg::bpf_decoded_t  decoded_i,
    input  bpf_exec_pkg::bpf_word_t     k_i,
    input  bpf_exec_pkg::bpf_word_t     alu_result_i,   // Registered ALU output
    output bpf_exec_pkg::bpf_word_t     op_a_o,
    output bpf_exec_pkg::bpf_word_t     op_b_o,
    output bpf_exec_pkg::bpf_word_t     a_o,
    output bpf_exec_pkg::bpf_word_t     x_o
);
    import bpf_isa_pkg::*;
    import bpf_exec_pkg::*;

    bpf_word_t a_q;           // Accumulator
    bpf_word_t x_q;           // Index register
    logic      wb_pending_q;  // The ALU result of the last issue belongs in A
    logic      alu_issue;

    // Only legal ALU-class work writes back, jumps leave A alone
    assign alu_issue = issue_i && decoded_i.is_alu && !decoded_i.illegal;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            a_q          <= '0;
            x_q          <= '0;
            wb_pending_q <= 1'b0;
        end else begin
            wb_pending_q <= alu_issue; // Result is registered at the issue edge, so copy one later

            // Writeback wins over the host, which is not supposed to collide with it anyway
            if (wb_pending_q) begin
                a_q <= alu_result_i;
            end else if (reg_wr_i && (reg_wr_sel_i == REG_SEL_A)) begin
                a_q <= reg_wr_data_i;
            end

            if (reg_wr_i && (reg_wr_sel_i == REG_SEL_X)) begin
                x_q <= reg_wr_data_i;
            end
        end
    end

    // A is always the first operand
    assign op_a_o = a_q;

    // The source bit picks the immediate or X
    assign op_b_o = (decoded_i.src_x == SRC_K) ? k_i : x_q;

    assign a_o = a_q;
    assign x_o = x_q;

endmodule

/* source/bpf_decoder.sv */
module bpf_decoder (
    input  bpf_exec_pkg::bpf_instr_t   instr_i,
    output bpf_exec_pkg::bpf_decoded_t decoded_o
);
    import bpf_isa_pkg::*;

    bpf_class_t                  cls;         // Instruction class from the low opcode bits
    logic [OP_MSB-OP_LSB:0]      op_field;    // Operation or condition nibble
    logic                        src_bit;
    logic                        alu_op_ok;
    logic                        jmp_cond_ok;
    logic                        class_alu;
    logic                        class_jmp;

    assign cls      = instr_i.opcode[CLASS_MSB:CLASS_LSB];
    assign op_field = instr_i.opcode[OP_MSB:OP_LSB];
    assign src_bit  = instr_i.opcode[SRC_BIT];

    assign class_alu = (cls == CLASS_ALU);
    assign class_jmp = (cls == CLASS_JMP);

    // Op values above xor have no meaning in the ALU class
    assign alu_op_ok = (op_field <= ALU_XOR);

    // Jump conditions stop at jset
    assign jmp_cond_ok = (op_field <= JMP_JSET);

    always_comb begin
        decoded_o.is_alu = class_alu;
        decoded_o.is_jmp = class_jmp;
        decoded_o.src_x  = src_bit; // Neg and ja ignore it later on

        // Jumps only need the flags, so the ALU runs a subtract for them
        // and the result port shows A minus the operand
        if (class_jmp) begin
            decoded_o.alu_op = ALU_SUB;
        end else begin
            decoded_o.alu_op = bpf_alu_op_t'(op_field);
        end

        // The condition field is only looked at by the branch unit for jumps
        decoded_o.jmp_cond = bpf_jmp_cond_t'(op_field);

        // Loads, stores, ret and misc are not executed here
        case (cls)
            CLASS_ALU: begin
                decoded_o.illegal = !alu_op_ok;
            end
            CLASS_JMP: begin
                decoded_o.illegal = !jmp_cond_ok;
            end
            default: begin
                decoded_o.illegal = 1'b1;
            end
        endcase
    end

endmodule

/* source/bpf_exec_pkg.sv */
package bpf_exec_pkg;

    typedef logic [31:0] bpf_word_t;   // Accumulator, index and immediate width
    typedef logic [7:0]  bpf_offset_t; // Relative jump distance in instructions

    // Host side register select
    typedef logic bpf_reg_sel_t;

    localparam bpf_reg_sel_t REG_SEL_A = 1'b0;
    localparam bpf_reg_sel_t REG_SEL_X = 1'b1;

    // One classic BPF instruction, in the order of struct sock_filter
    typedef struct packed {
        bpf_isa_pkg::bpf_opcode_t opcode;
        bpf_offset_t              jt;     // Distance when the condition holds
        bpf_offset_t              jf;     // Distance when it does not
        bpf_word_t                k;      // Immediate operand
    } bpf_instr_t;

    // What the decoder tells the rest of the stage
    typedef struct packed {
        logic                       is_alu;
        logic                       is_jmp;
        logic                       illegal;  // Unknown class or op value
        bpf_isa_pkg::bpf_alu_op_t   alu_op;
        logic                       src_x;    // Raw source bit of the opcode
        bpf_isa_pkg::bpf_jmp_cond_t jmp_cond;
    } bpf_decoded_t;

    // Comparison of A with the second operand, all unsigned
    typedef struct packed {
        logic eq;
        logic gt;
        logic ge;
        logic set;  // A and the operand have a common one bit
    } bpf_flags_t;

endpackage

/* source/bpf_isa_pkg.sv */
package bpf_isa_pkg;

    // Raw instruction fields as classic BPF defines them
    typedef logic [15:0] bpf_opcode_t;   // Only the low byte carries meaning
    typedef logic [2:0]  bpf_class_t;
    typedef logic [3:0]  bpf_alu_op_t;   // Same value as the op field of ALU-class opcodes
    typedef logic [3:0]  bpf_jmp_cond_t; // Same value as the op field of JMP-class opcodes

    // Where the fields sit inside the opcode
    localparam int CLASS_LSB = 0;
    localparam int CLASS_MSB = 2;
    localparam int SRC_BIT   = 3;
    localparam int OP_LSB    = 4;
    localparam int OP_MSB    = 7;

    localparam bpf_class_t CLASS_ALU = 3'd4;
    localparam bpf_class_t CLASS_JMP = 3'd5;

    localparam logic SRC_K = 1'b0; // Second operand is the immediate
    localparam logic SRC_X = 1'b1; // Second operand is the index register

    localparam bpf_alu_op_t ALU_ADD = 4'h0;
    localparam bpf_alu_op_t ALU_SUB = 4'h1;
    localparam bpf_alu_op_t ALU_MUL = 4'h2;
    localparam bpf_alu_op_t ALU_DIV = 4'h3;
    localparam bpf_alu_op_t ALU_OR  = 4'h4;
    localparam bpf_alu_op_t ALU_AND = 4'h5;
    localparam bpf_alu_op_t ALU_LSH = 4'h6;
    localparam bpf_alu_op_t ALU_RSH = 4'h7;
    localparam bpf_alu_op_t ALU_NEG = 4'h8;
    localparam bpf_alu_op_t ALU_MOD = 4'h9;
    localparam bpf_alu_op_t ALU_XOR = 4'ha;

    localparam bpf_jmp_cond_t JMP_JA   = 4'h0;
    localparam bpf_jmp_cond_t JMP_JEQ  = 4'h1;
    localparam bpf_jmp_cond_t JMP_JGT  = 4'h2;
    localparam bpf_jmp_cond_t JMP_JGE  = 4'h3;
    localparam bpf_jmp_cond_t JMP_JSET = 4'h4;

    // Words returned in place of the operations that are not built
    localparam logic [31:0] MUL_MARKER = 32'hcafedead;
    localparam logic [31:0] DIV_MARKER = 32'hdeadbeef;
    localparam logic [31:0] MOD_MARKER = 32'hbeefcafe;

endpackage
